//--- verilog/seq_consts.svh
`ifndef SEQ_CONSTS_SVH
`define SEQ_CONSTS_SVH

// Register bus widths.
`define SEQ_ADDR_W 16
`define SEQ_DATA_W 32

`define SEQ_NUM_CH 4

// Address map.
`define SEQ_CTRL_ADDR 8'h20
`define SEQ_RATE_ADDR 8'h21
`define SEQ_CH_BASE 8'h22
`define SEQ_CH_STRIDE 3

// Sequencer clock in Hz.
`define SEQ_CLOCKRATE 25000000

`endif

//--- verilog/seq_reg_pkg.sv
`include "seq_consts.svh"

package seq_reg_pkg;

	typedef logic [`SEQ_ADDR_W-1:0] addr_t;
	typedef logic [`SEQ_DATA_W-1:0] data_t;

	// Global control word, run in bit 0.
	typedef struct packed {
		logic [29:0] spare;
		logic soft_reset;
		logic run;
	} ctrl_t;

endpackage

//--- verilog/seq_chan_pkg.sv
`include "seq_consts.svh"

package seq_chan_pkg;

	// Cycles per phase, minus one.
	typedef logic [`SEQ_DATA_W-1:0] count_t;

	typedef struct packed {
		logic [29:0] spare;
		logic initial_level;
		logic enable;
	} chan_cfg_t;

endpackage

//--- verilog/seq_register.sv
`include "seq_consts.svh"

module seq_register #(
	parameter seq_reg_pkg::addr_t ADDR = '0,
	parameter type value_t = seq_reg_pkg::data_t,
	parameter value_t RESET_VALUE = '0
) (
	input  logic               clk,
	input  logic               reset,
	input  seq_reg_pkg::addr_t reg_addr,
	input  seq_reg_pkg::data_t reg_wdata,
	input  logic               reg_wr,
	input  logic               reg_rd,
	output value_t             value
);

	logic hit;

	assign hit = reg_wr && (reg_addr == ADDR);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			value <= RESET_VALUE;
		end
		else if (hit)
		begin
			value <= value_t'(reg_wdata); // Visible next cycle.
		end
	end

	// The host issues one access per cycle.
	assert property (@(posedge clk) disable iff (reset) !(reg_wr && reg_rd))
		else $error("reg_wr and reg_rd high together");

endmodule

//--- verilog/seq_control.sv
`include "seq_consts.svh"

module seq_control (
	input  logic               clk,
	input  logic               reset,
	input  seq_reg_pkg::addr_t reg_addr,
	input  seq_reg_pkg::data_t reg_wdata,
	input  logic               reg_wr,
	input  logic               reg_rd,
	output logic               run,
	output logic               soft_reset,
	output logic               rd_hit,
	output seq_reg_pkg::data_t rd_data
);

	localparam seq_reg_pkg::addr_t CTRL_ADDR = seq_reg_pkg::addr_t'(`SEQ_CTRL_ADDR);
	localparam seq_reg_pkg::addr_t RATE_ADDR = seq_reg_pkg::addr_t'(`SEQ_RATE_ADDR);

	seq_reg_pkg::ctrl_t ctrl;

	seq_register #(
		.ADDR(CTRL_ADDR),
		.value_t(seq_reg_pkg::ctrl_t),
		.RESET_VALUE('0)
	) ctrl_reg (
		.clk(clk),
		.reset(reset),
		.reg_addr(reg_addr),
		.reg_wdata(reg_wdata),
		.reg_wr(reg_wr),
		.reg_rd(reg_rd),
		.value(ctrl)
	);

	assign run = ctrl.run;
	assign soft_reset = ctrl.soft_reset;

	// The clock rate is constant and ignores writes.
	always_comb
	begin
		rd_hit = 1'b1;
		case (reg_addr)
			CTRL_ADDR:
			begin
				rd_data = seq_reg_pkg::data_t'(ctrl);
			end
			RATE_ADDR:
			begin
				rd_data = seq_reg_pkg::data_t'(`SEQ_CLOCKRATE);
			end
			default:
			begin
				rd_hit = 1'b0;
				rd_data = '0;
			end
		endcase
	end

endmodule

//--- verilog/seq_channel.sv
`include "seq_consts.svh"

module seq_channel #(
	parameter seq_reg_pkg::addr_t BASE = seq_reg_pkg::addr_t'(`SEQ_CH_BASE)
) (
	input  logic               clk,
	input  logic               reset,
	input  logic               run,
	input  logic               soft_reset,
	input  seq_reg_pkg::addr_t reg_addr,
	input  seq_reg_pkg::data_t reg_wdata,
	input  logic               reg_wr,
	output logic               out,
	output logic               rd_hit,
	output seq_reg_pkg::data_t rd_data
);

	localparam seq_reg_pkg::addr_t CFG_ADDR = BASE;
	localparam seq_reg_pkg::addr_t LOW_ADDR = BASE + 1;
	localparam seq_reg_pkg::addr_t HIGH_ADDR = BASE + 2;

	seq_chan_pkg::chan_cfg_t cfg;
	seq_chan_pkg::count_t low_count;
	seq_chan_pkg::count_t high_count;
	seq_chan_pkg::count_t counter;
	logic advance;

	seq_register #(
		.ADDR(CFG_ADDR),
		.value_t(seq_chan_pkg::chan_cfg_t),
		.RESET_VALUE('0)
	) cfg_reg (
		.clk(clk),
		.reset(reset),
		.reg_addr(reg_addr),
		.reg_wdata(reg_wdata),
		.reg_wr(reg_wr),
		.reg_rd(1'b0),
		.value(cfg)
	);

	seq_register #(
		.ADDR(LOW_ADDR),
		.value_t(seq_chan_pkg::count_t),
		.RESET_VALUE('0)
	) low_count_reg (
		.clk(clk),
		.reset(reset),
		.reg_addr(reg_addr),
		.reg_wdata(reg_wdata),
		.reg_wr(reg_wr),
		.reg_rd(1'b0),
		.value(low_count)
	);

	seq_register #(
		.ADDR(HIGH_ADDR),
		.value_t(seq_chan_pkg::count_t),
		.RESET_VALUE('0)
	) high_count_reg (
		.clk(clk),
		.reset(reset),
		.reg_addr(reg_addr),
		.reg_wdata(reg_wdata),
		.reg_wr(reg_wr),
		.reg_rd(1'b0),
		.value(high_count)
	);

	assign advance = run && cfg.enable; // Stands in for a gated clock.

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			out <= 1'b0;
			counter <= '0;
		end
		else if (advance)
		begin
			if (soft_reset)
			begin
				out <= cfg.initial_level;
				counter <= cfg.initial_level ? high_count : low_count;
			end
			else if (counter != '0)
			begin
				counter <= counter - 1'b1;
			end
			else
			begin
				out <= !out;
				counter <= out ? low_count : high_count; // Count of the new level.
			end
		end
	end

	always_comb
	begin
		rd_hit = 1'b1;
		case (reg_addr)
			CFG_ADDR:  rd_data = seq_reg_pkg::data_t'(cfg);
			LOW_ADDR:  rd_data = low_count;
			HIGH_ADDR: rd_data = high_count;
			default:
			begin
				rd_hit = 1'b0;
				rd_data = '0;
			end
		endcase
	end

	assert property (@(posedge clk) disable iff (reset) !advance |=> $stable(out))
		else $error("channel output moved while frozen");

endmodule

//--- verilog/seq_readback.sv
`include "seq_consts.svh"

module seq_readback (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  reg_rd,
	input  logic                  ctrl_hit,
	input  seq_reg_pkg::data_t    ctrl_data,
	input  logic [`SEQ_NUM_CH-1:0] ch_hit,
	input  seq_reg_pkg::data_t    ch_data [`SEQ_NUM_CH],
	output seq_reg_pkg::data_t    reg_rdata,
	output logic                  reg_rvalid
);

	seq_reg_pkg::data_t sel_data;

	// Unmapped addresses read as zero.
	always_comb
	begin
		sel_data = '0;
		if (ctrl_hit)
		begin
			sel_data = ctrl_data;
		end
		for (int i = 0; i < `SEQ_NUM_CH; i++)
		begin
			if (ch_hit[i])
			begin
				sel_data = ch_data[i];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			reg_rvalid <= 1'b0;
			reg_rdata <= '0;
		end
		else
		begin
			reg_rvalid <= reg_rd; // One cycle after the strobe.
			if (reg_rd)
			begin
				reg_rdata <= sel_data;
			end
		end
	end

	// Address map has no overlaps between blocks.
	assert property (@(posedge clk) disable iff (reset) $onehot0({ctrl_hit, ch_hit}))
		else $error("overlapping read hits");

endmodule

//--- verilog/sequencer.sv
`include "seq_consts.svh"

module sequencer (
	input  logic                  clk,
	input  logic                  reset,
	input  seq_reg_pkg::addr_t    reg_addr,
	input  seq_reg_pkg::data_t    reg_wdata,
	input  logic                  reg_wr,
	input  logic                  reg_rd,
	output seq_reg_pkg::data_t    reg_rdata,
	output logic                  reg_rvalid,
	output logic [`SEQ_NUM_CH-1:0] outputs
);

	logic run;
	logic soft_reset;
	logic ctrl_hit;
	seq_reg_pkg::data_t ctrl_data;
	logic [`SEQ_NUM_CH-1:0] ch_hit;
	seq_reg_pkg::data_t ch_data [`SEQ_NUM_CH];

	seq_control control (
		.clk(clk),
		.reset(reset),
		.reg_addr(reg_addr),
		.reg_wdata(reg_wdata),
		.reg_wr(reg_wr),
		.reg_rd(reg_rd),
		.run(run),
		.soft_reset(soft_reset),
		.rd_hit(ctrl_hit),
		.rd_data(ctrl_data)
	);

	// Channel i owns three consecutive addresses.
	for (genvar i = 0; i < `SEQ_NUM_CH; i++)
	begin : g_ch
		seq_channel #(
			.BASE(seq_reg_pkg::addr_t'(`SEQ_CH_BASE + i * `SEQ_CH_STRIDE))
		) channel (
			.clk(clk),
			.reset(reset),
			.run(run),
			.soft_reset(soft_reset),
			.reg_addr(reg_addr),
			.reg_wdata(reg_wdata),
			.reg_wr(reg_wr),
			.out(outputs[i]),
			.rd_hit(ch_hit[i]),
			.rd_data(ch_data[i])
		);
	end

	seq_readback readback (
		.clk(clk),
		.reset(reset),
		.reg_rd(reg_rd),
		.ctrl_hit(ctrl_hit),
		.ctrl_data(ctrl_data),
		.ch_hit(ch_hit),
		.ch_data(ch_data),
		.reg_rdata(reg_rdata),
		.reg_rvalid(reg_rvalid)
	);

endmodule

//--- dv/sequencer_checks.sv
`include "seq_consts.svh"

module sequencer_checks (
	input logic                   clk,
	input logic                   reset,
	input seq_reg_pkg::addr_t     reg_addr,
	input seq_reg_pkg::data_t     reg_wdata,
	input logic                   reg_wr,
	input logic                   reg_rd,
	input seq_reg_pkg::data_t     reg_rdata,
	input logic                   reg_rvalid,
	input logic [`SEQ_NUM_CH-1:0] outputs
);
	timeunit 1ns;
	timeprecision 100ps;

	seq_reg_pkg::ctrl_t m_ctrl;
	seq_chan_pkg::chan_cfg_t m_cfg [`SEQ_NUM_CH];
	seq_chan_pkg::count_t m_low [`SEQ_NUM_CH];
	seq_chan_pkg::count_t m_high [`SEQ_NUM_CH];
	seq_chan_pkg::count_t m_left [`SEQ_NUM_CH]; // Advancing cycles left in the level.
	logic [`SEQ_NUM_CH-1:0] m_out;
	seq_reg_pkg::data_t exp_rdata;
	int errors = 0;

	function automatic seq_reg_pkg::addr_t base_of(int ch);
		return seq_reg_pkg::addr_t'(`SEQ_CH_BASE + ch * `SEQ_CH_STRIDE);
	endfunction

	function automatic seq_chan_pkg::count_t phase_len(int ch, logic level);
		return level ? m_high[ch] : m_low[ch];
	endfunction

	function automatic seq_reg_pkg::data_t model_read(seq_reg_pkg::addr_t addr);
		int offset;
		model_read = '0;
		offset = int'(addr) - `SEQ_CH_BASE;
		if (addr == `SEQ_CTRL_ADDR)
			model_read = m_ctrl;
		else if (addr == `SEQ_RATE_ADDR)
			model_read = `SEQ_CLOCKRATE;
		else if (offset >= 0 && offset < `SEQ_NUM_CH * `SEQ_CH_STRIDE)
		begin
			case (offset % `SEQ_CH_STRIDE)
				0: model_read = m_cfg[offset / `SEQ_CH_STRIDE];
				1: model_read = m_low[offset / `SEQ_CH_STRIDE];
				default: model_read = m_high[offset / `SEQ_CH_STRIDE];
			endcase
		end
	endfunction

	always @(posedge clk)
	begin
		if (reset)
		begin
			m_ctrl <= '0;
			m_out <= '0;
			exp_rdata <= '0;
			for (int i = 0; i < `SEQ_NUM_CH; i++)
			begin
				m_cfg[i] <= '0;
				m_low[i] <= '0;
				m_high[i] <= '0;
				m_left[i] <= '0;
			end
		end
		else
		begin
			for (int i = 0; i < `SEQ_NUM_CH; i++)
			begin
				if (m_ctrl.run && m_cfg[i].enable)
				begin
					if (m_ctrl.soft_reset)
					begin
						m_out[i] <= m_cfg[i].initial_level;
						m_left[i] <= phase_len(i, m_cfg[i].initial_level);
					end
					else if (m_left[i] > 0)
						m_left[i] <= m_left[i] - 1;
					else
					begin
						m_out[i] <= !m_out[i];
						m_left[i] <= phase_len(i, !m_out[i]);
					end
				end
				if (reg_wr && reg_addr == base_of(i))
					m_cfg[i] <= reg_wdata;
				if (reg_wr && reg_addr == base_of(i) + 1)
					m_low[i] <= reg_wdata;
				if (reg_wr && reg_addr == base_of(i) + 2)
					m_high[i] <= reg_wdata;
			end
			if (reg_wr && reg_addr == `SEQ_CTRL_ADDR)
				m_ctrl <= reg_wdata;
			if (reg_rd)
				exp_rdata <= model_read(reg_addr); // Due with reg_rvalid.
		end
	end

	a_outputs: assert property (@(posedge clk) disable iff (reset) outputs == m_out)
		else
		begin
			errors++;
			$error("ERR %s: outputs expected %b, actual %b", sequencer_tb.test_name,
				$sampled(m_out), $sampled(outputs));
		end

	a_rvalid: assert property (@(posedge clk) disable iff (reset) reg_rvalid == $past(reg_rd))
		else
		begin
			errors++;
			$error("ERR %s: reg_rvalid expected %b, actual %b", sequencer_tb.test_name,
				$past(reg_rd), $sampled(reg_rvalid));
		end

	a_rdata: assert property (@(posedge clk) disable iff (reset)
		reg_rvalid |-> reg_rdata == exp_rdata)
		else
		begin
			errors++;
			$error("ERR %s: reg_rdata expected %h, actual %h", sequencer_tb.test_name,
				$sampled(exp_rdata), $sampled(reg_rdata));
		end

endmodule

//--- dv/sequencer_tb.sv
`include "seq_consts.svh"

module sequencer_tb;
	timeunit 1ns;
	timeprecision 100ps;

	// Worst-case cycles per test.
	localparam int RESET_CYCLES = 24;
	localparam int READBACK_CYCLES = 48;
	localparam int RATE_CYCLES = 16;
	localparam int WAVE_CYCLES = 140;
	localparam int FREEZE_CYCLES = 180;
	localparam int LIMIT = 2 * (RESET_CYCLES + READBACK_CYCLES + RATE_CYCLES + WAVE_CYCLES
		+ FREEZE_CYCLES);
	localparam seq_reg_pkg::addr_t CTRL = `SEQ_CTRL_ADDR;
	localparam seq_reg_pkg::addr_t RATE = `SEQ_RATE_ADDR;

	logic clk = 1'b0;
	logic reset;
	seq_reg_pkg::addr_t reg_addr;
	seq_reg_pkg::data_t reg_wdata;
	logic reg_wr;
	logic reg_rd;
	seq_reg_pkg::data_t reg_rdata;
	logic reg_rvalid;
	logic [`SEQ_NUM_CH-1:0] outputs;

	string test_name = "none";
	integer seed;
	int errors = 0;
	int passed = 0;
	int failed = 0;
	int mark = 0;
	int cycles = 0;
	seq_reg_pkg::data_t cfg_word [`SEQ_NUM_CH];
	seq_chan_pkg::count_t low_cnt [`SEQ_NUM_CH];
	seq_chan_pkg::count_t high_cnt [`SEQ_NUM_CH];
	logic [`SEQ_NUM_CH-1:0] init_lvl;
	logic [`SEQ_NUM_CH-1:0] frozen;

	sequencer uut (
		.clk(clk),
		.reset(reset),
		.reg_addr(reg_addr),
		.reg_wdata(reg_wdata),
		.reg_wr(reg_wr),
		.reg_rd(reg_rd),
		.reg_rdata(reg_rdata),
		.reg_rvalid(reg_rvalid),
		.outputs(outputs)
	);

	bind sequencer sequencer_checks checks (
		.clk(clk),
		.reset(reset),
		.reg_addr(reg_addr),
		.reg_wdata(reg_wdata),
		.reg_wr(reg_wr),
		.reg_rd(reg_rd),
		.reg_rdata(reg_rdata),
		.reg_rvalid(reg_rvalid),
		.outputs(outputs)
	);

	always #20 clk = ~clk;

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= LIMIT)
		begin
			$display("Timeout: run took more than %0d cycles", LIMIT);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	function automatic seq_reg_pkg::addr_t ch_addr(int ch, int index);
		return seq_reg_pkg::addr_t'(`SEQ_CH_BASE + ch * `SEQ_CH_STRIDE + index);
	endfunction

	function automatic int total_errors();
		return errors + uut.checks.errors;
	endfunction

	// Bus tasks start and end just after a falling edge.
	task automatic write_reg(input seq_reg_pkg::addr_t addr, input seq_reg_pkg::data_t data);
		reg_addr = addr;
		reg_wdata = data;
		reg_wr = 1'b1;
		@(negedge clk);
		reg_wr = 1'b0;
	endtask

	task automatic read_reg(input seq_reg_pkg::addr_t addr, output seq_reg_pkg::data_t data);
		reg_addr = addr;
		reg_rd = 1'b1;
		@(negedge clk);
		reg_rd = 1'b0;
		assert (reg_rvalid)
			else
			begin
				errors++;
				$display("%s: read of address %h got no response", test_name, addr);
			end
		data = reg_rdata;
	endtask

	task automatic expect_value(input string what, input seq_reg_pkg::data_t exp,
		input seq_reg_pkg::data_t act);
		assert (act == exp)
			else
			begin
				errors++;
				$display("ERR %s: %s expected %h, actual %h", test_name, what, exp, act);
			end
	endtask

	task automatic expect_read(input seq_reg_pkg::addr_t addr, input seq_reg_pkg::data_t exp);
		seq_reg_pkg::data_t got;
		read_reg(addr, got);
		expect_value($sformatf("read of %h", addr), exp, got);
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) @(negedge clk);
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		mark = total_errors();
	endtask

	task automatic end_test();
		if (total_errors() == mark)
		begin
			passed++;
			$display("%s: passed", test_name);
		end
		else
		begin
			failed++;
			$display("%s: failed", test_name);
		end
	endtask

	initial
	begin
		seed = 32'hd4cb_cdaa;
		reset = 1'b1;
		reg_addr = '0;
		reg_wdata = '0;
		reg_wr = 1'b0;
		reg_rd = 1'b0;
		repeat (4) @(negedge clk);
		reset = 1'b0;

		begin_test("reset_state");
		expect_value("outputs", '0, outputs);
		expect_value("reg_rvalid", '0, reg_rvalid);
		expect_read(CTRL, '0);
		for (int ch = 0; ch < `SEQ_NUM_CH; ch++)
			for (int r = 0; r < `SEQ_CH_STRIDE; r++)
				expect_read(ch_addr(ch, r), '0);
		end_test();

		begin_test("register_readback");
		for (int ch = 0; ch < `SEQ_NUM_CH; ch++)
		begin
			cfg_word[ch] = $random(seed);
			low_cnt[ch] = $random(seed) & 15;
			high_cnt[ch] = $random(seed) & 15;
			write_reg(ch_addr(ch, 0), cfg_word[ch]);
			write_reg(ch_addr(ch, 1), low_cnt[ch]);
			write_reg(ch_addr(ch, 2), high_cnt[ch]);
		end
		for (int ch = 0; ch < `SEQ_NUM_CH; ch++)
		begin
			expect_read(ch_addr(ch, 0), cfg_word[ch]);
			expect_read(ch_addr(ch, 1), low_cnt[ch]);
			expect_read(ch_addr(ch, 2), high_cnt[ch]);
		end
		write_reg(CTRL, 32'ha5a5_0000); // Spare bits only.
		expect_read(CTRL, 32'ha5a5_0000);
		idle_cycles(1);
		expect_value("reg_rvalid after response", '0, reg_rvalid);
		write_reg(CTRL, '0);
		end_test();

		begin_test("rate_and_unmapped");
		expect_read(RATE, `SEQ_CLOCKRATE);
		write_reg(RATE, 32'h1234_5678);
		expect_read(RATE, `SEQ_CLOCKRATE);
		expect_read(16'h0000, '0);
		expect_read(16'h001f, '0);
		expect_read(ch_addr(`SEQ_NUM_CH, 0), '0);
		expect_read(16'h0120, '0);
		expect_read(16'hffff, '0);
		end_test();

		begin_test("waveform_timing");
		for (int ch = 0; ch < `SEQ_NUM_CH; ch++)
		begin
			init_lvl[ch] = $random(seed) & 1;
			low_cnt[ch] = $random(seed) & 15;
			high_cnt[ch] = $random(seed) & 15;
			write_reg(ch_addr(ch, 0), {30'b0, init_lvl[ch], 1'b1});
			write_reg(ch_addr(ch, 1), low_cnt[ch]);
			write_reg(ch_addr(ch, 2), high_cnt[ch]);
		end
		write_reg(CTRL, 32'h3); // Run with soft reset.
		write_reg(CTRL, 32'h1);
		expect_value("initial levels", init_lvl, outputs);
		idle_cycles(100);
		end_test();

		begin_test("freeze_and_resume");
		write_reg(ch_addr(0, 0), {30'b0, init_lvl[0], 1'b0});
		frozen = outputs;
		idle_cycles(30);
		expect_value("disabled channel 0", frozen[0], outputs[0]);
		write_reg(CTRL, '0);
		frozen = outputs;
		idle_cycles(30);
		expect_value("frozen outputs", frozen, outputs);
		write_reg(CTRL, 32'h1);
		idle_cycles(60);
		end_test();

		$display("Tests passed: %0d, failed: %0d", passed, failed);
		if (failed == 0 && total_errors() == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

//--- all.f
+incdir+verilog
verilog/seq_reg_pkg.sv
verilog/seq_chan_pkg.sv
verilog/seq_register.sv
verilog/seq_control.sv
verilog/seq_channel.sv
verilog/seq_readback.sv
verilog/sequencer.sv
dv/sequencer_checks.sv
dv/sequencer_tb.sv

//--- Bender.yml
package:
  name: sequencer

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/seq_reg_pkg.sv
      - verilog/seq_chan_pkg.sv
      - verilog/seq_register.sv
      - verilog/seq_control.sv
      - verilog/seq_channel.sv
      - verilog/seq_readback.sv
      - verilog/sequencer.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - dv/sequencer_checks.sv
      - dv/sequencer_tb.sv
